// ==== cpu.f ====
+incdir+tb
hw/cpu_pkg.sv
hw/fetch.sv
hw/regfile.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/cpu.sv
tb/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - files:
      - hw/cpu_pkg.sv
      - hw/fetch.sv
      - hw/regfile.sv
      - hw/decode.sv
      - hw/execute.sv
      - hw/memory.sv
      - hw/cpu.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/cpu_tb.sv

// ==== tb/cpu_programs.svh ====
// Instruction encoders take each field from the low bits of its argument
function automatic word_t r_insn(int f7, int rs2, int rs1, int f3, int rd);
	return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
endfunction

function automatic word_t i_insn(int imm, int rs1, int f3, int rd, logic [6:0] opc);
	return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic word_t s_insn(int imm, int rs2, int rs1, int f3);
	return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
endfunction

function automatic word_t b_insn(int imm, int rs2, int rs1, int f3);
	return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic word_t u_insn(int imm, int rd, logic [6:0] opc);
	return {imm[19:0], rd[4:0], opc};
endfunction

function automatic word_t j_insn(int imm, int rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
endfunction

// I/O slot k sits at 0x0001_0000 + 4k
// x31 holds the I/O base
// Dependent instructions are kept at least three words apart
task automatic load_program();
	prog.delete();
	prog.push_back(u_insn(32'h00010, 31, OPC_LUI));
	prog.push_back(u_insn(32'h12345, 1, OPC_LUI));
	prog.push_back(i_insn(-7, 0, 0, 2, OPC_OPIMM));
	prog.push_back(i_insn(5, 0, 0, 3, OPC_OPIMM));
	prog.push_back(u_insn(1, 4, OPC_AUIPC));
	prog.push_back(i_insn(32'h678, 1, 6, 5, OPC_OPIMM));
	prog.push_back(r_insn(7'h20, 2, 3, 0, 6));
	prog.push_back(r_insn(0, 3, 2, 2, 7));
	prog.push_back(r_insn(0, 3, 2, 3, 8));
	prog.push_back(i_insn(32'h401, 2, 5, 9, OPC_OPIMM));
	prog.push_back(i_insn(4, 2, 5, 10, OPC_OPIMM));
	prog.push_back(r_insn(0, 3, 3, 1, 11));
	prog.push_back(r_insn(0, 2, 5, 4, 12));
	prog.push_back(i_insn(32'h0f0, 5, 7, 13, OPC_OPIMM));
	prog.push_back(s_insn(4 * 1, 1, 31, 2));
	for (int k = 4; k <= 13; k++) begin
		prog.push_back(s_insn(4 * k, k, 31, 2));
	end
	// SW, then SH to the upper half and SB to byte 1 of word 0x100
	prog.push_back(s_insn(32'h100, 5, 0, 2));
	prog.push_back(s_insn(32'h102, 12, 0, 1));
	prog.push_back(s_insn(32'h101, 2, 0, 0));
	prog.push_back(i_insn(32'h100, 0, 2, 14, OPC_LOAD));
	prog.push_back(i_insn(32'h102, 0, 1, 15, OPC_LOAD));
	prog.push_back(i_insn(32'h100, 0, 5, 16, OPC_LOAD));
	prog.push_back(i_insn(32'h101, 0, 0, 17, OPC_LOAD));
	prog.push_back(i_insn(32'h103, 0, 4, 18, OPC_LOAD));
	for (int k = 14; k <= 18; k++) begin
		prog.push_back(s_insn(4 * k, k, 31, 2));
	end
	// Taken beq skips slot 20
	prog.push_back(b_insn(12, 3, 3, 0));
	prog.push_back(s_insn(4 * 19, 3, 31, 2));
	prog.push_back(s_insn(4 * 20, 3, 31, 2));
	// Not-taken bne falls through to slot 22
	prog.push_back(b_insn(12, 3, 3, 1));
	prog.push_back(s_insn(4 * 21, 6, 31, 2));
	prog.push_back(s_insn(4 * 22, 7, 31, 2));
	prog.push_back(b_insn(12, 3, 2, 4));
	prog.push_back(s_insn(4 * 23, 8, 31, 2));
	prog.push_back(s_insn(4 * 24, 9, 31, 2));
	// jal at word 47 and jalr at word 50 jumping to word 53
	prog.push_back(j_insn(12, 19));
	prog.push_back(s_insn(4 * 25, 10, 31, 2));
	prog.push_back(s_insn(4 * 26, 11, 31, 2));
	prog.push_back(i_insn(212, 0, 0, 21, OPC_JALR));
	prog.push_back(s_insn(4 * 27, 19, 31, 2));
	prog.push_back(s_insn(4 * 28, 12, 31, 2));
	prog.push_back(i_insn(0, 31, 2, 22, OPC_LOAD));
	prog.push_back(s_insn(4 * 29, 21, 31, 2));
	prog.push_back(NOP_INSN);
	prog.push_back(i_insn(32'h123, 22, 0, 23, OPC_OPIMM));
	prog.push_back(NOP_INSN);
	prog.push_back(NOP_INSN);
	prog.push_back(s_insn(4 * 30, 23, 31, 2));
	prog.push_back({25'b0, OPC_SYSTEM});
	prog.push_back(NOP_INSN);
	// Never fetched once halted
	prog.push_back(s_insn(4 * 31, 3, 31, 2));
endtask

task automatic expect_write(int test, int slot, word_t data);
	exp_addr.push_back(32'h0001_0000 + word_t'(4 * slot));
	exp_data.push_back(data);
	exp_test.push_back(test);
endtask

task automatic build_expected(word_t joy);
	word_t       x1;
	word_t       x2;
	word_t       x3;
	word_t       x5;
	word_t       x6;
	word_t       x7;
	word_t       x8;
	word_t       x10;
	word_t       x12;
	logic [32:0] borrow_diff;
	word_t       merged;
	x1  = 32'h12345 << 12;
	x2  = word_t'(-7);
	x3  = 32'd5;
	x5  = x1 | 32'h678;
	x12 = x5 ^ x2;
	// Two's complement subtraction
	x6  = x3 + ~x2 + 32'd1;
	// Opposite signs order by the sign bit alone
	x7  = {31'b0, ((x2[31] != x3[31]) ? x2[31] : (x2 < x3))};
	// Unsigned less-than is the borrow out of the subtraction
	borrow_diff = {1'b0, x2} - {1'b0, x3};
	x8  = {31'b0, borrow_diff[32]};
	x10 = {4'b0, x2[31:4]};
	expect_write(2, 1, x1);
	expect_write(2, 4, 32'd16 + (32'd1 << 12));
	expect_write(2, 5, x5);
	expect_write(2, 6, x6);
	expect_write(2, 7, x7);
	expect_write(2, 8, x8);
	// Sign bit fills the vacated top bit
	expect_write(2, 9, {x2[31], x2[31:1]});
	expect_write(2, 10, x10);
	// Shift amount is x3 itself
	expect_write(2, 11, {x3[26:0], 5'b0});
	expect_write(2, 12, x12);
	expect_write(2, 13, x5 & 32'h0f0);
	merged = {x12[15:0], x2[7:0], x5[7:0]};
	expect_write(3, 14, merged);
	expect_write(3, 15, {{16{merged[31]}}, merged[31:16]});
	expect_write(3, 16, {16'b0, merged[15:0]});
	expect_write(3, 17, {{24{merged[15]}}, merged[15:8]});
	expect_write(3, 18, {24'b0, merged[31:24]});
	expect_write(4, 19, x3);
	expect_write(4, 21, x6);
	expect_write(4, 22, x7);
	expect_write(4, 23, x8);
	expect_write(4, 25, x10);
	// Link values are the jump's own address plus 4
	expect_write(4, 27, 32'd4 * 47 + 32'd4);
	expect_write(4, 29, 32'd4 * 50 + 32'd4);
	expect_write(5, 30, joy + 32'h123);
endtask

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	// Loading plus about sixty instructions and the drain fit well inside
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int DRAIN_CYCLES = 8;

	logic   clk;
	logic   rst_n;
	logic   debug;
	word_t  joystick_data;
	word_t  data_cpu;
	word_t  waddr_cpu;
	word_t  waddr_out;
	word_t  data_out;
	logic   io_we;
	logic   halt;

	word_t  prog [$];
	word_t  exp_addr [$];
	word_t  exp_data [$];
	int     exp_test [$];
	integer seed = 64875;
	int     cycles = 0;
	int     n_writes = 0;
	int     errors = 0;
	int     test_errors = 0;
	int     tests_failed = 0;
	logic   halt_seen = 1'b0;
	string  test_names [7] = '{"", "reset and load idle", "ALU and immediate results",
		"byte, half and word memory access", "branches, jumps and delay slots",
		"I/O load of joystick_data", "halt after ECALL"};

	`include "cpu_programs.svh"

	cpu DUT (.*);

	always #5 clk = ~clk;

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic finish_test(int id);
		if (test_errors == 0) begin
			$display("Test %0d %s: ok", id, test_names[id]);
		end else begin
			$display("Test %0d %s: %0d errors", id, test_names[id], test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	// Compares one I/O write against the next entry of the expected list
	task automatic check_write();
		assert (n_writes < exp_addr.size()) else begin
			$display("Unexpected I/O write to %h at %0t ns after all expected writes",
				waddr_out, $time);
			note_error();
		end
		if (n_writes < exp_addr.size()) begin
			assert (waddr_out == exp_addr[n_writes]) else begin
				$display("FAILED at %0t ns: waddr_out expected %h, got %h", $time,
					exp_addr[n_writes], waddr_out);
				note_error();
			end
			assert (data_out == exp_data[n_writes]) else begin
				$display("FAILED at %0t ns: data_out expected %h, got %h", $time,
					exp_data[n_writes], data_out);
				note_error();
			end
			n_writes++;
			if (n_writes == exp_addr.size() ||
				exp_test[n_writes] != exp_test[n_writes - 1]) begin
				finish_test(exp_test[n_writes - 1]);
			end
		end
	endtask

	// Outputs are sampled half a cycle away from the active edge
	always @(negedge clk) begin
		if (rst_n && debug) begin
			assert (io_we == 1'b0) else begin
				$display("FAILED at %0t ns: io_we expected 0, got %b", $time, io_we);
				note_error();
			end
			assert (halt == 1'b0) else begin
				$display("FAILED at %0t ns: halt expected 0, got %b", $time, halt);
				note_error();
			end
		end
		if (rst_n && !debug && io_we) begin
			check_write();
		end
		if (halt_seen) begin
			assert (halt == 1'b1) else begin
				$display("halt dropped at %0t ns after it had been raised", $time);
				note_error();
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the core never halted", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		debug         = 1'b1;
		data_cpu      = '0;
		waddr_cpu     = '0;
		joystick_data = $random(seed);
		load_program();
		build_expected(joystick_data);
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// Bootloader writes one word per cycle
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			data_cpu  <= prog[i];
			waddr_cpu <= word_t'(4 * i);
		end
		@(posedge clk);
		debug <= 1'b0;
		@(negedge clk);
		finish_test(1);

		while (!halt) begin
			@(negedge clk);
		end
		halt_seen = 1'b1;
		// Long enough for every stage behind ECALL to empty
		repeat (DRAIN_CYCLES) @(negedge clk);
		assert (n_writes == exp_addr.size()) else begin
			$display("FAILED at %0t ns: I/O write count expected %0d, got %0d", $time,
				exp_addr.size(), n_writes);
			note_error();
		end
		finish_test(6);

		$display("%0d tests run, %0d failed, %0d failed checks", 6, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== hw/cpu.sv ====
`timescale 1ns/1ps

module cpu (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           debug,
	input  cpu_pkg::word_t joystick_data,
	input  cpu_pkg::word_t data_cpu,
	input  cpu_pkg::word_t waddr_cpu,
	output cpu_pkg::word_t waddr_out,
	output cpu_pkg::word_t data_out,
	output logic           io_we,
	output logic           halt
);
	import cpu_pkg::*;

	// Fetch to decode
	word_t     if_pc;
	word_t     if_pc_plus4;
	word_t     if_insn;

	// Decode to fetch, and register file read port
	logic      branch_taken;
	word_t     branch_target;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t     rs1_data;
	word_t     rs2_data;

	// ID/EX
	word_t     id_op1;
	word_t     id_op2;
	word_t     id_imm;
	word_t     id_pc;
	word_t     id_pc_plus4;
	logic      id_imm_sel;
	logic      id_pc_as_operand;
	logic      id_zero_op1;
	logic      id_link;
	alu_op_t   id_alu_op;
	logic      id_mem_read;
	logic      id_mem_write;
	mem_type_t id_mem_type;
	logic      id_reg_we;
	reg_addr_t id_rd;

	// EX/MEM
	word_t     ex_result;
	word_t     ex_store_data;
	reg_addr_t ex_rd;
	logic      ex_reg_we;
	logic      ex_mem_read;
	logic      ex_mem_write;
	mem_type_t ex_mem_type;

	// MEM/WB
	word_t     wb_result;
	word_t     wb_load_data;
	reg_addr_t wb_rd;
	logic      wb_reg_we;
	logic      wb_mem_read;
	word_t     wb_data;

	fetch i_fetch (.*);

	decode i_decode (.*);

	regfile i_regfile (
		.*,
		.rd_addr(wb_rd),
		.rd_we  (wb_reg_we),
		.rd_data(wb_data)
	);

	execute i_execute (.*);

	memory i_memory (.*);

	// Writeback select
	assign wb_data = wb_mem_read ? wb_load_data : wb_result;

endmodule

// ==== hw/memory.sv ====
`timescale 1ns/1ps

module memory (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::word_t     ex_result,
	input  cpu_pkg::word_t     ex_store_data,
	input  cpu_pkg::reg_addr_t ex_rd,
	input  logic               ex_reg_we,
	input  logic               ex_mem_read,
	input  logic               ex_mem_write,
	input  cpu_pkg::mem_type_t ex_mem_type,
	input  cpu_pkg::word_t     joystick_data,
	output cpu_pkg::word_t     waddr_out,
	output cpu_pkg::word_t     data_out,
	output logic               io_we,
	output cpu_pkg::word_t     wb_result,
	output cpu_pkg::word_t     wb_load_data,
	output cpu_pkg::reg_addr_t wb_rd,
	output logic               wb_reg_we,
	output logic               wb_mem_read
);
	import cpu_pkg::*;

	logic       is_io;
	logic [7:0] dmem_idx;
	logic [3:0] byte_en;
	word_t      wdata;
	word_t      rdata;
	word_t      lane_data;
	word_t      load_ext;
	word_t      dmem [DMEM_WORDS];

	// Upper half nonzero selects I/O
	assign is_io    = |ex_result[31:16];
	assign dmem_idx = ex_result[9:2];

	// Store data copied to every lane, enables pick the lanes written
	always_comb begin
		case (ex_mem_type[1:0])
			2'b00: begin
				wdata   = {4{ex_store_data[7:0]}};
				byte_en = 4'b0001 << ex_result[1:0];
			end
			2'b01: begin
				wdata   = {2{ex_store_data[15:0]}};
				byte_en = ex_result[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				wdata   = ex_store_data;
				byte_en = 4'b1111;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (ex_mem_write && !is_io) begin
			for (int i = 0; i < 4; i++) begin
				if (byte_en[i]) begin
					dmem[dmem_idx][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	assign rdata     = dmem[dmem_idx];
	assign lane_data = rdata >> {ex_result[1:0], 3'b000};

	// Bit 2 of the type marks the unsigned loads
	always_comb begin
		case (ex_mem_type[1:0])
			2'b00: load_ext = {{24{lane_data[7] & ~ex_mem_type[2]}}, lane_data[7:0]};
			2'b01: load_ext = {{16{lane_data[15] & ~ex_mem_type[2]}}, lane_data[15:0]};
			default: load_ext = rdata;
		endcase
	end

	assign waddr_out = ex_result;
	assign data_out  = ex_store_data;
	assign io_we     = ex_mem_write & is_io;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_reg_we   <= 1'b0;
			wb_mem_read <= 1'b0;
		end else begin
			wb_reg_we   <= ex_reg_we;
			wb_mem_read <= ex_mem_read;
		end
	end

	// MEM/WB payload
	always_ff @(posedge clk) begin
		wb_result    <= ex_result;
		wb_load_data <= is_io ? joystick_data : load_ext;
		wb_rd        <= ex_rd;
	end

endmodule

// ==== hw/execute.sv ====
`timescale 1ns/1ps

module execute (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::word_t     id_op1,
	input  cpu_pkg::word_t     id_op2,
	input  cpu_pkg::word_t     id_imm,
	input  cpu_pkg::word_t     id_pc,
	input  cpu_pkg::word_t     id_pc_plus4,
	input  logic               id_imm_sel,
	input  logic               id_pc_as_operand,
	input  logic               id_zero_op1,
	input  logic               id_link,
	input  cpu_pkg::alu_op_t   id_alu_op,
	input  logic               id_mem_read,
	input  logic               id_mem_write,
	input  cpu_pkg::mem_type_t id_mem_type,
	input  logic               id_reg_we,
	input  cpu_pkg::reg_addr_t id_rd,
	output cpu_pkg::word_t     ex_result,
	output cpu_pkg::word_t     ex_store_data,
	output cpu_pkg::reg_addr_t ex_rd,
	output logic               ex_reg_we,
	output logic               ex_mem_read,
	output logic               ex_mem_write,
	output cpu_pkg::mem_type_t ex_mem_type
);
	import cpu_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t alu_out;

	// Zero for LUI, PC for AUIPC
	assign op_a = id_zero_op1 ? '0 : (id_pc_as_operand ? id_pc : id_op1);
	assign op_b = id_imm_sel ? id_imm : id_op2;

	always_comb begin
		case (id_alu_op)
			ALU_SUB:  alu_out = op_a - op_b;
			ALU_SLL:  alu_out = op_a << op_b[4:0];
			ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_out = {31'b0, op_a < op_b};
			ALU_XOR:  alu_out = op_a ^ op_b;
			ALU_SRL:  alu_out = op_a >> op_b[4:0];
			ALU_SRA:  alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
			ALU_OR:   alu_out = op_a | op_b;
			ALU_AND:  alu_out = op_a & op_b;
			default:  alu_out = op_a + op_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_reg_we    <= 1'b0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
		end else begin
			ex_reg_we    <= id_reg_we;
			ex_mem_read  <= id_mem_read;
			ex_mem_write <= id_mem_write;
		end
	end

	// Jumps write back the return address
	always_ff @(posedge clk) begin
		ex_result     <= id_link ? id_pc_plus4 : alu_out;
		ex_store_data <= id_op2;
		ex_rd         <= id_rd;
		ex_mem_type   <= id_mem_type;
	end

endmodule

// ==== hw/decode.sv ====
`timescale 1ns/1ps

module decode (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::word_t     if_pc,
	input  cpu_pkg::word_t     if_pc_plus4,
	input  cpu_pkg::word_t     if_insn,
	input  cpu_pkg::word_t     rs1_data,
	input  cpu_pkg::word_t     rs2_data,
	output cpu_pkg::reg_addr_t rs1_addr,
	output cpu_pkg::reg_addr_t rs2_addr,
	output logic               branch_taken,
	output cpu_pkg::word_t     branch_target,
	output logic               halt,
	output cpu_pkg::word_t     id_op1,
	output cpu_pkg::word_t     id_op2,
	output cpu_pkg::word_t     id_imm,
	output cpu_pkg::word_t     id_pc,
	output cpu_pkg::word_t     id_pc_plus4,
	output logic               id_imm_sel,
	output logic               id_pc_as_operand,
	output logic               id_zero_op1,
	output logic               id_link,
	output cpu_pkg::alu_op_t   id_alu_op,
	output logic               id_mem_read,
	output logic               id_mem_write,
	output cpu_pkg::mem_type_t id_mem_type,
	output logic               id_reg_we,
	output cpu_pkg::reg_addr_t id_rd
);
	import cpu_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	word_t      imm;
	logic       imm_sel;
	logic       pc_as_operand;
	logic       zero_op1;
	logic       link;
	alu_op_t    alu_op;
	logic       mem_read;
	logic       mem_write;
	logic       reg_we;
	logic       is_ecall;
	logic       cond;

	assign opcode   = if_insn[6:0];
	assign funct3   = if_insn[14:12];
	assign rs1_addr = if_insn[19:15];
	assign rs2_addr = if_insn[24:20];

	assign imm_i = {{20{if_insn[31]}}, if_insn[31:20]};
	assign imm_s = {{20{if_insn[31]}}, if_insn[31:25], if_insn[11:7]};
	assign imm_b = {{19{if_insn[31]}}, if_insn[31], if_insn[7], if_insn[30:25],
		if_insn[11:8], 1'b0};
	assign imm_u = {if_insn[31:12], 12'b0};
	assign imm_j = {{11{if_insn[31]}}, if_insn[31], if_insn[19:12], if_insn[20],
		if_insn[30:21], 1'b0};

	always_comb begin
		case (funct3)
			3'b000:  cond = rs1_data == rs2_data;
			3'b001:  cond = rs1_data != rs2_data;
			3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);
			3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data);
			3'b110:  cond = rs1_data < rs2_data;
			3'b111:  cond = rs1_data >= rs2_data;
			default: cond = 1'b0;
		endcase
	end

	// Anything not matched falls out as a no-op
	always_comb begin
		imm           = imm_i;
		imm_sel       = 1'b0;
		pc_as_operand = 1'b0;
		zero_op1      = 1'b0;
		link          = 1'b0;
		alu_op        = ALU_ADD;
		mem_read      = 1'b0;
		mem_write     = 1'b0;
		reg_we        = 1'b0;
		is_ecall      = 1'b0;
		branch_taken  = 1'b0;
		branch_target = if_pc + imm_b;
		case (opcode)
			OPC_LUI: begin
				imm      = imm_u;
				imm_sel  = 1'b1;
				zero_op1 = 1'b1;
				reg_we   = 1'b1;
			end
			OPC_AUIPC: begin
				imm           = imm_u;
				imm_sel       = 1'b1;
				pc_as_operand = 1'b1;
				reg_we        = 1'b1;
			end
			OPC_JAL: begin
				link          = 1'b1;
				reg_we        = 1'b1;
				branch_taken  = 1'b1;
				branch_target = if_pc + imm_j;
			end
			OPC_JALR: begin
				link          = 1'b1;
				reg_we        = 1'b1;
				branch_taken  = 1'b1;
				branch_target = (rs1_data + imm_i) & ~32'd1;
			end
			OPC_BRANCH: branch_taken = cond;
			OPC_LOAD: begin
				imm_sel  = 1'b1;
				mem_read = 1'b1;
				reg_we   = 1'b1;
			end
			OPC_STORE: begin
				imm       = imm_s;
				imm_sel   = 1'b1;
				mem_write = 1'b1;
			end
			OPC_OPIMM: begin
				imm_sel = 1'b1;
				reg_we  = 1'b1;
				// Only SRAI uses bit 30, elsewhere it is immediate
				alu_op  = {funct3 == 3'b101 && if_insn[30], funct3};
			end
			OPC_OP: begin
				reg_we = 1'b1;
				alu_op = {if_insn[30], funct3};
			end
			OPC_SYSTEM: is_ecall = funct3 == 3'b000 && if_insn[31:20] == 12'd0;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halt         <= 1'b0;
			id_reg_we    <= 1'b0;
			id_mem_read  <= 1'b0;
			id_mem_write <= 1'b0;
		end else begin
			if (is_ecall) begin
				halt <= 1'b1;
			end
			id_reg_we    <= reg_we;
			id_mem_read  <= mem_read;
			id_mem_write <= mem_write;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		id_op1           <= rs1_data;
		id_op2           <= rs2_data;
		id_imm           <= imm;
		id_pc            <= if_pc;
		id_pc_plus4      <= if_pc_plus4;
		id_imm_sel       <= imm_sel;
		id_pc_as_operand <= pc_as_operand;
		id_zero_op1      <= zero_op1;
		id_link          <= link;
		id_alu_op        <= alu_op;
		id_mem_type      <= funct3;
		id_rd            <= if_insn[11:7];
	end

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::reg_addr_t rs1_addr,
	input  cpu_pkg::reg_addr_t rs2_addr,
	input  cpu_pkg::reg_addr_t rd_addr,
	input  logic               rd_we,
	input  cpu_pkg::word_t     rd_data,
	output cpu_pkg::word_t     rs1_data,
	output cpu_pkg::word_t     rs2_data
);
	import cpu_pkg::*;

	// Entry 0 is never written
	word_t regs [32];

	// x0 reads zero, a same-cycle write to the register goes straight through
	function automatic word_t read_port(reg_addr_t addr, word_t stored);
		if (addr == '0) begin
			return '0;
		end
		if (rd_we && rd_addr == addr) begin
			return rd_data;
		end
		return stored;
	endfunction

	always_comb begin
		rs1_data = read_port(rs1_addr, regs[rs1_addr]);
		rs2_data = read_port(rs2_addr, regs[rs2_addr]);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_we && rd_addr != '0) begin
			regs[rd_addr] <= rd_data;
		end
	end

endmodule

// ==== hw/fetch.sv ====
`timescale 1ns/1ps

module fetch (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           debug,
	input  cpu_pkg::word_t data_cpu,
	input  cpu_pkg::word_t waddr_cpu,
	input  logic           branch_taken,
	input  cpu_pkg::word_t branch_target,
	input  logic           halt,
	output cpu_pkg::word_t if_pc,
	output cpu_pkg::word_t if_pc_plus4,
	output cpu_pkg::word_t if_insn
);
	import cpu_pkg::*;

	word_t pc;
	word_t pc_plus4;
	word_t imem [IMEM_WORDS];

	assign pc_plus4 = pc + 32'd4;

	// Bootloader write port, one word per cycle while debug is high
	always_ff @(posedge clk) begin
		if (debug) begin
			imem[waddr_cpu[9:2]] <= data_cpu;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || debug) begin
			pc <= '0;
		end else if (!halt) begin
			if (branch_taken) begin
				pc <= branch_target;
			end else begin
				pc <= pc_plus4;
			end
		end
	end

	// IF/ID register
	// Bubbles go in while loading and once halted so the pipe drains
	always_ff @(posedge clk) begin
		if (!rst_n || debug || halt) begin
			if_insn <= NOP_INSN;
		end else begin
			if_insn <= imem[pc[9:2]];
		end
	end

	always_ff @(posedge clk) begin
		if_pc       <= pc;
		if_pc_plus4 <= pc_plus4;
	end

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	// Data, address and instruction word
	typedef logic [31:0] word_t;

	typedef logic [4:0] reg_addr_t;
	typedef logic [3:0] alu_op_t;

	// Load/store size and sign, same encoding as funct3
	typedef logic [2:0] mem_type_t;

	// Low three bits follow funct3, bit 3 marks the alternate form
	localparam alu_op_t ALU_ADD  = 4'b0000;
	localparam alu_op_t ALU_SLL  = 4'b0001;
	localparam alu_op_t ALU_SLT  = 4'b0010;
	localparam alu_op_t ALU_SLTU = 4'b0011;
	localparam alu_op_t ALU_XOR  = 4'b0100;
	localparam alu_op_t ALU_SRL  = 4'b0101;
	localparam alu_op_t ALU_OR   = 4'b0110;
	localparam alu_op_t ALU_AND  = 4'b0111;
	localparam alu_op_t ALU_SUB  = 4'b1000;
	localparam alu_op_t ALU_SRA  = 4'b1101;

	// RV32I major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// Memory depths in words
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;

	// addi x0, x0, 0
	localparam word_t NOP_INSN = 32'h0000_0013;

endpackage
